// File: common/commitPkg.sv
package commitPkg;

    ////////////////////////////////////////
    // Micro-op encodings
    ////////////////////////////////////////

    // Control transfer carried by a micro-op
    typedef enum logic [2:0] {
        typeNormal,
        typeCond,
        typeJump,
        typeCall,
        typeRet
    } branchKindT;

    typedef enum logic [1:0] {
        uopPlain,
        uopBranch,
        uopDelaySlot
    } uopKindT;

    ////////////////////////////////////////
    // Sizes
    ////////////////////////////////////////

    localparam int PC_WIDTH = 32;

    localparam int ROB_DEPTH = 8;
    localparam int ROB_PTR_WIDTH = 3;

    // Branch plus its delay slot
    localparam int SEQ_NEXT_OFFSET = 8;

    // Index is pc[5:2], tag is pc[31:6]
    localparam int BTB_ENTRIES = 16;
    localparam int BTB_INDEX_WIDTH = 4;
    localparam int BTB_TAG_WIDTH = 26;

endpackage

// File: common/robCommitIf.sv
`timescale 1ns/10ps

interface robCommitIf;

    // Oldest entry of the queue
    logic                                headValid;
    logic [commitPkg::PC_WIDTH-1:0]      headPc;
    commitPkg::uopKindT                  headKind;
    commitPkg::branchKindT               headBranchKind;
    logic                                headTaken;
    logic                                headPredTaken;
    logic [commitPkg::PC_WIDTH-1:0]      headTarget;
    logic [commitPkg::PC_WIDTH-1:0]      headPredTarget;

    // Control back from the commit unit
    logic                                headPop;
    logic                                flush;
    logic                                holdInput;

    modport queue (
        output headValid, headPc, headKind, headBranchKind, headTaken,
               headPredTaken, headTarget, headPredTarget,
        input  headPop, flush, holdInput
    );

    modport commit (
        input  headValid, headPc, headKind, headBranchKind, headTaken,
               headPredTaken, headTarget, headPredTarget,
        output headPop, flush, holdInput
    );

endinterface

// File: common/backendIf.sv
`timescale 1ns/10ps

interface backendIf;

    // Fetch redirect and pipeline flush
    logic                                redirectValid;
    logic [commitPkg::PC_WIDTH-1:0]      redirectPc;
    logic                                flushReq;

    // Predictor training from committed branches
    logic                                updValid;
    logic [commitPkg::PC_WIDTH-1:0]      updPc;
    logic                                updTaken;
    logic [commitPkg::PC_WIDTH-1:0]      updTarget;
    commitPkg::branchKindT               updBranchKind;

    modport commit (
        output redirectValid, redirectPc, flushReq,
        output updValid, updPc, updTaken, updTarget, updBranchKind
    );

    modport btb (
        input updValid, updPc, updTaken, updTarget, updBranchKind
    );

    modport top (
        input redirectValid, redirectPc, flushReq
    );

endinterface

// File: rob/robQueue.sv
`timescale 1ns/10ps

module robQueue (
    input  logic                              clk,
    input  logic                              rstN,
    input  logic                              inValid,
    output logic                              inReady,
    input  logic [commitPkg::PC_WIDTH-1:0]    inPc,
    input  commitPkg::uopKindT                inKind,
    input  commitPkg::branchKindT             inBranchKind,
    input  logic                              inTaken,
    input  logic                              inPredTaken,
    input  logic [commitPkg::PC_WIDTH-1:0]    inTarget,
    input  logic [commitPkg::PC_WIDTH-1:0]    inPredTarget,
    robCommitIf.queue                         rob
);

    typedef struct packed {
        logic [commitPkg::PC_WIDTH-1:0]    pc;
        commitPkg::uopKindT                kind;
        commitPkg::branchKindT             branchKind;
        logic                              taken;
        logic                              predTaken;
        logic [commitPkg::PC_WIDTH-1:0]    target;
        logic [commitPkg::PC_WIDTH-1:0]    predTarget;
    } robEntryT;

    robEntryT                                entries [commitPkg::ROB_DEPTH];
    logic [commitPkg::ROB_PTR_WIDTH-1:0]     wrPtr;
    logic [commitPkg::ROB_PTR_WIDTH-1:0]     rdPtr;
    logic [commitPkg::ROB_PTR_WIDTH:0]       count;
    logic                                    full;
    logic                                    push;
    logic                                    pop;

    assign full = count == (commitPkg::ROB_PTR_WIDTH + 1)'(commitPkg::ROB_DEPTH);
    // Refuse pushes while a redirect is on its way
    assign inReady = !full && !rob.holdInput;
    assign push = inValid && inReady;
    assign pop = rob.headPop && rob.headValid;

    ////////////////////////////////////////
    // Head presentation
    ////////////////////////////////////////

    assign rob.headValid = count != '0;
    assign rob.headPc = entries[rdPtr].pc;
    assign rob.headKind = entries[rdPtr].kind;
    assign rob.headBranchKind = entries[rdPtr].branchKind;
    assign rob.headTaken = entries[rdPtr].taken;
    assign rob.headPredTaken = entries[rdPtr].predTaken;
    assign rob.headTarget = entries[rdPtr].target;
    assign rob.headPredTarget = entries[rdPtr].predTarget;

    // Payload storage
    always_ff @(posedge clk) begin
        if (push) begin
            entries[wrPtr] <= '{pc: inPc, kind: inKind, branchKind: inBranchKind,
                                taken: inTaken, predTaken: inPredTaken,
                                target: inTarget, predTarget: inPredTarget};
        end
    end

    // Pointers and occupancy, flush beats push
    always_ff @(posedge clk) begin
        if (!rstN || rob.flush) begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
        end else begin
            if (push) begin
                wrPtr <= wrPtr + 1'b1;
            end
            if (pop) begin
                rdPtr <= rdPtr + 1'b1;
            end
            count <= count + (push ? 1'b1 : 1'b0) - (pop ? 1'b1 : 1'b0);
        end
    end

    // Write pointer caught up with a non-empty queue means full
    noPushWhenFull: assert property (@(posedge clk) disable iff (!rstN)
        (wrPtr == rdPtr && count != '0) |-> !push);

endmodule

// File: commit/commitUnit.sv
`timescale 1ns/10ps

module commitUnit (
    input  logic                              clk,
    input  logic                              rstN,
    input  logic                              stallReq,
    robCommitIf.commit                        rob,
    backendIf.commit                          backend,
    output logic                              commitValid,
    output logic [commitPkg::PC_WIDTH-1:0]    commitPc
);

    typedef enum logic [1:0] {
        stIdle,
        stWaitSlot,
        stRedirect
    } commitStateT;

    commitStateT                        state;
    logic                               takeMiss;
    logic                               targetMiss;
    logic                               mispredict;
    logic                               isBranch;
    logic [commitPkg::PC_WIDTH-1:0]     resolvedPc;
    logic [commitPkg::PC_WIDTH-1:0]     pendingPc;

    ////////////////////////////////////////
    // Misprediction check on the head
    ////////////////////////////////////////

    assign isBranch = rob.headBranchKind != commitPkg::typeNormal;
    assign takeMiss = isBranch && (rob.headTaken != rob.headPredTaken);
    // Target only matters when the branch was taken
    assign targetMiss = rob.headTaken && (rob.headTarget != rob.headPredTarget);
    assign mispredict = takeMiss || targetMiss;

    assign resolvedPc = rob.headTaken ? rob.headTarget
                      : rob.headPc + commitPkg::PC_WIDTH'(commitPkg::SEQ_NEXT_OFFSET);

    // No pop during the redirect cycle
    assign rob.headPop = rob.headValid && !stallReq && (state != stRedirect);
    assign commitValid = rob.headPop;
    assign commitPc = rob.headPc;

    always_ff @(posedge clk) begin
        if (!rstN) begin
            state <= stIdle;
        end else begin
            case (state)
                stIdle: begin
                    if (rob.headPop && mispredict) begin
                        state <= stWaitSlot;
                    end
                end
                // Next committed micro-op is the delay slot
                stWaitSlot: begin
                    if (rob.headPop) begin
                        state <= stRedirect;
                    end
                end
                default: state <= stIdle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == stIdle && rob.headPop && mispredict) begin
            pendingPc <= resolvedPc;
        end
    end

    ////////////////////////////////////////
    // Outputs to queue, fetch and BTB
    ////////////////////////////////////////

    assign rob.flush = state == stRedirect;
    assign rob.holdInput = state != stIdle;

    assign backend.redirectValid = state == stRedirect;
    assign backend.redirectPc = pendingPc;
    assign backend.flushReq = rob.flush;

    assign backend.updValid = rob.headPop && isBranch;
    assign backend.updPc = rob.headPc;
    assign backend.updTaken = rob.headTaken;
    assign backend.updTarget = rob.headTarget;
    assign backend.updBranchKind = rob.headBranchKind;

    redirectIsFlush: assert property (@(posedge clk) disable iff (!rstN)
        backend.redirectValid == backend.flushReq);

    // Micro-op retired behind a mispredicted branch is its delay slot
    slotKindMatches: assert property (@(posedge clk) disable iff (!rstN)
        (state == stWaitSlot && rob.headPop) |-> rob.headKind == commitPkg::uopDelaySlot);

endmodule

// File: logic/branchTargetBuffer.sv
`timescale 1ns/10ps

module branchTargetBuffer (
    input  logic                              clk,
    input  logic                              rstN,
    backendIf.btb                             backend,
    input  logic [commitPkg::PC_WIDTH-1:0]    lookupPc,
    output logic                              lookupHit,
    output logic                              lookupTaken,
    output logic [commitPkg::PC_WIDTH-1:0]    lookupTarget
);

    logic [commitPkg::BTB_ENTRIES-1:0]        validBits;
    logic [commitPkg::BTB_TAG_WIDTH-1:0]      tags [commitPkg::BTB_ENTRIES];
    logic [commitPkg::PC_WIDTH-1:0]           targets [commitPkg::BTB_ENTRIES];
    logic [commitPkg::BTB_ENTRIES-1:0]        takenBits;
    logic [commitPkg::BTB_INDEX_WIDTH-1:0]    updIndex;
    logic [commitPkg::BTB_TAG_WIDTH-1:0]      updTag;
    logic [commitPkg::BTB_INDEX_WIDTH-1:0]    lookupIndex;
    logic [commitPkg::BTB_TAG_WIDTH-1:0]      lookupTag;
    logic                                     updAlwaysTaken;

    // Word-aligned PCs, low two bits dropped
    assign updIndex = backend.updPc[commitPkg::BTB_INDEX_WIDTH+1:2];
    assign updTag = backend.updPc[commitPkg::PC_WIDTH-1 -: commitPkg::BTB_TAG_WIDTH];
    assign lookupIndex = lookupPc[commitPkg::BTB_INDEX_WIDTH+1:2];
    assign lookupTag = lookupPc[commitPkg::PC_WIDTH-1 -: commitPkg::BTB_TAG_WIDTH];

    // Unconditional transfers always train as taken
    assign updAlwaysTaken = backend.updBranchKind inside
        {commitPkg::typeJump, commitPkg::typeCall, commitPkg::typeRet};

    ////////////////////////////////////////
    // Update on commit
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!rstN) begin
            validBits <= '0;
        end else if (backend.updValid) begin
            validBits[updIndex] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (backend.updValid) begin
            tags[updIndex] <= updTag;
            targets[updIndex] <= backend.updTarget;
            takenBits[updIndex] <= backend.updTaken || updAlwaysTaken;
        end
    end

    // Combinational lookup
    assign lookupHit = validBits[lookupIndex] && (tags[lookupIndex] == lookupTag);
    assign lookupTaken = lookupHit && takenBits[lookupIndex];
    assign lookupTarget = targets[lookupIndex];

endmodule

// File: logic/commitSubsystem.sv
`timescale 1ns/10ps

module commitSubsystem (
    input  logic                              clk,
    input  logic                              rstN,
    input  logic                              inValid,
    output logic                              inReady,
    input  logic [commitPkg::PC_WIDTH-1:0]    inPc,
    input  commitPkg::uopKindT                inKind,
    input  commitPkg::branchKindT             inBranchKind,
    input  logic                              inTaken,
    input  logic                              inPredTaken,
    input  logic [commitPkg::PC_WIDTH-1:0]    inTarget,
    input  logic [commitPkg::PC_WIDTH-1:0]    inPredTarget,
    input  logic                              stallReq,
    output logic                              commitValid,
    output logic [commitPkg::PC_WIDTH-1:0]    commitPc,
    output logic                              redirectValid,
    output logic [commitPkg::PC_WIDTH-1:0]    redirectPc,
    output logic                              flushReq,
    input  logic [commitPkg::PC_WIDTH-1:0]    lookupPc,
    output logic                              lookupHit,
    output logic                              lookupTaken,
    output logic [commitPkg::PC_WIDTH-1:0]    lookupTarget
);

    robCommitIf robBus ();
    backendIf   backendBus ();

    robQueue queueInst (
        .clk          (clk),
        .rstN         (rstN),
        .inValid      (inValid),
        .inReady      (inReady),
        .inPc         (inPc),
        .inKind       (inKind),
        .inBranchKind (inBranchKind),
        .inTaken      (inTaken),
        .inPredTaken  (inPredTaken),
        .inTarget     (inTarget),
        .inPredTarget (inPredTarget),
        .rob          (robBus.queue)
    );

    commitUnit commitInst (
        .clk         (clk),
        .rstN        (rstN),
        .stallReq    (stallReq),
        .rob         (robBus.commit),
        .backend     (backendBus.commit),
        .commitValid (commitValid),
        .commitPc    (commitPc)
    );

    branchTargetBuffer btbInst (
        .clk          (clk),
        .rstN         (rstN),
        .backend      (backendBus.btb),
        .lookupPc     (lookupPc),
        .lookupHit    (lookupHit),
        .lookupTaken  (lookupTaken),
        .lookupTarget (lookupTarget)
    );

    // Redirect out to the fetch side
    assign redirectValid = backendBus.redirectValid;
    assign redirectPc = backendBus.redirectPc;
    assign flushReq = backendBus.flushReq;

endmodule

// File: tests/clockGen.sv
`timescale 1ns/10ps

module clockGen (
    output logic clk,
    output logic rstN
);

    // 20 ns period
    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // Reset held for 8 cycles, released on a falling edge
    initial begin
        rstN = 1'b0;
        repeat (8) @(posedge clk);
        @(negedge clk);
        rstN = 1'b1;
    end

endmodule

// File: tests/commitChecker.sv
`timescale 1ns/10ps

module commitChecker (
    input  logic                              clk,
    input  logic                              rstN,
    input  logic                              inReady,
    input  logic                              commitValid,
    input  logic [commitPkg::PC_WIDTH-1:0]    commitPc,
    input  logic                              redirectValid,
    input  logic [commitPkg::PC_WIDTH-1:0]    redirectPc,
    input  logic                              flushReq,
    input  logic                              lookupHit,
    input  logic                              lookupTaken,
    input  logic [commitPkg::PC_WIDTH-1:0]    lookupTarget
);

    // Expected retirement order, slot flag, miss flag and redirect target per entry
    logic [commitPkg::PC_WIDTH-1:0]    expPc [$];
    logic                              expSlot [$];
    logic                              expMiss [$];
    logic [commitPkg::PC_WIDTH-1:0]    expRedirect [$];

    logic                              redirectDue;
    logic                              holdDue;
    logic [commitPkg::PC_WIDTH-1:0]    dueTarget;
    logic                              missPending;
    logic                              dropping;
    logic [commitPkg::PC_WIDTH-1:0]    missTarget;
    int                                currentTest;
    int                                testErrors;
    int                                testsRun;
    int                                testsFailed;

    task automatic reportMismatch(input string msg);
        $display("[FAIL] time %0t: %s", $time, msg);
        testErrors++;
    endtask

    task automatic reportProblem(input string msg);
        $display("Test %0d went wrong at %0t: %s", currentTest, $time, msg);
        testErrors++;
    endtask

    task automatic startTest(input int id);
        currentTest = id;
        missPending = 1'b0;
        dropping = 1'b0;
        holdDue = 1'b0;
    endtask

    ////////////////////////////////////////
    // Reference model of one pushed group
    ////////////////////////////////////////

    task automatic addEntry(
        input logic [commitPkg::PC_WIDTH-1:0] pc,
        input commitPkg::branchKindT          bkind,
        input bit                             taken,
        input bit                             predTaken,
        input logic [commitPkg::PC_WIDTH-1:0] target,
        input logic [commitPkg::PC_WIDTH-1:0] predTarget
    );
        bit miss;
        miss = (bkind != commitPkg::typeNormal && taken != predTaken)
            || (taken && target != predTarget);
        // Wrong path after the delay slot is flushed
        if (!dropping) begin
            expPc.push_back(pc);
            expSlot.push_back(missPending);
            expMiss.push_back(!missPending && miss);
            expRedirect.push_back(missTarget);
            if (missPending) begin
                missPending = 1'b0;
                dropping = 1'b1;
            end else if (miss) begin
                missPending = 1'b1;
                missTarget = taken ? target : pc + commitPkg::SEQ_NEXT_OFFSET;
            end
        end
    endtask

    always @(posedge clk) begin
        if (!rstN) begin
            redirectDue = 1'b0;
            holdDue = 1'b0;
        end else begin
            if (flushReq !== redirectValid) begin
                reportMismatch($sformatf("flushReq %b but redirectValid %b",
                    flushReq, redirectValid));
            end
            // Input held from the mispredicted branch through the flush cycle
            if (holdDue && inReady !== 1'b0) begin
                reportMismatch($sformatf("inReady %b while input is held", inReady));
            end else if (!holdDue && expPc.size() == 0 && inReady !== 1'b1) begin
                reportMismatch($sformatf("inReady %b with an empty queue", inReady));
            end
            if (redirectDue) begin
                if (redirectValid !== 1'b1) begin
                    reportProblem("no redirect in the cycle after the delay slot");
                end else if (redirectPc !== dueTarget) begin
                    reportMismatch($sformatf("redirectPc %h, expected %h",
                        redirectPc, dueTarget));
                end
                holdDue = 1'b0;
            end else if (redirectValid === 1'b1) begin
                reportProblem("redirect raised without a delay slot just before it");
            end
            redirectDue = 1'b0;
            if (commitValid === 1'b1) begin
                if (expPc.size() == 0) begin
                    reportProblem($sformatf("unexpected commit of pc %h", commitPc));
                end else begin
                    if (commitPc !== expPc[0]) begin
                        reportMismatch($sformatf("commitPc %h, expected %h",
                            commitPc, expPc[0]));
                    end
                    redirectDue = expSlot[0];
                    dueTarget = expRedirect[0];
                    if (expMiss[0]) begin
                        holdDue = 1'b1;
                    end
                    void'(expPc.pop_front());
                    void'(expSlot.pop_front());
                    void'(expMiss.pop_front());
                    void'(expRedirect.pop_front());
                end
            end
        end
    end

    task automatic checkLookup(
        input logic [commitPkg::PC_WIDTH-1:0] pc,
        input bit                             hit,
        input bit                             taken,
        input logic [commitPkg::PC_WIDTH-1:0] target
    );
        if (lookupHit !== hit || lookupTaken !== taken || (hit && lookupTarget !== target)) begin
            reportMismatch($sformatf("lookup %h gave %b %b %h, expected %b %b %h",
                pc, lookupHit, lookupTaken, lookupTarget, hit, taken, target));
        end
    endtask

    task automatic finishTest();
        if (expPc.size() != 0) begin
            reportProblem($sformatf("%0d expected commits never appeared", expPc.size()));
            expPc.delete();
            expSlot.delete();
            expMiss.delete();
            expRedirect.delete();
        end
        testsRun++;
        if (testErrors == 0) begin
            $display("Test %0d passed", currentTest);
        end else begin
            testsFailed++;
            $display("Test %0d failed with %0d errors", currentTest, testErrors);
        end
        testErrors = 0;
    endtask

    task automatic printCounts();
        $display("Tests run %0d, passed %0d, failed %0d",
            testsRun, testsRun - testsFailed, testsFailed);
    endtask

endmodule

// File: tests/commitTb.sv
`timescale 1ns/10ps

module commitTb;

    logic                              clk;
    logic                              rstN;
    logic                              inValid;
    logic                              inReady;
    logic [commitPkg::PC_WIDTH-1:0]    inPc;
    commitPkg::uopKindT                inKind;
    commitPkg::branchKindT             inBranchKind;
    logic                              inTaken;
    logic                              inPredTaken;
    logic [commitPkg::PC_WIDTH-1:0]    inTarget;
    logic [commitPkg::PC_WIDTH-1:0]    inPredTarget;
    logic                              stallReq;
    logic                              commitValid;
    logic [commitPkg::PC_WIDTH-1:0]    commitPc;
    logic                              redirectValid;
    logic [commitPkg::PC_WIDTH-1:0]    redirectPc;
    logic                              flushReq;
    logic [commitPkg::PC_WIDTH-1:0]    lookupPc;
    logic                              lookupHit;
    logic                              lookupTaken;
    logic [commitPkg::PC_WIDTH-1:0]    lookupTarget;

    string                             lines [$];
    logic [commitPkg::PC_WIDTH-1:0]    gapPcs [$];
    int                                numTests;
    int                                badLines;

    clockGen clockInst (.clk(clk), .rstN(rstN));

    commitSubsystem commitSubsystem_i (.*);

    commitChecker checkerInst (.*);

    task automatic reportBadLine(input string line);
        $display("Data file line not understood: %s", line);
        badLines++;
    endtask

    ////////////////////////////////////////
    // Stimulus from the data file
    ////////////////////////////////////////

    task automatic pushEntry(input string line);
        logic [commitPkg::PC_WIDTH-1:0] pc;
        logic [commitPkg::PC_WIDTH-1:0] target;
        logic [commitPkg::PC_WIDTH-1:0] predTarget;
        int kind;
        int bkind;
        int taken;
        int predTaken;
        int gap;
        if ($sscanf(line, "E %h %d %d %d %d %h %h %d", pc, kind, bkind, taken,
                predTaken, target, predTarget, gap) != 8) begin
            reportBadLine(line);
        end else begin
            // Late delay slot, pushed after a gap and held back at commit
            if (gap != 0) begin
                repeat ($urandom_range(6, 1)) @(negedge clk);
                gapPcs.push_back(pc);
            end
            while (!inReady) @(negedge clk);
            inValid = 1'b1;
            inPc = pc;
            inKind = commitPkg::uopKindT'(kind);
            inBranchKind = commitPkg::branchKindT'(bkind);
            inTaken = taken != 0;
            inPredTaken = predTaken != 0;
            inTarget = target;
            inPredTarget = predTarget;
            checkerInst.addEntry(pc, inBranchKind, taken != 0, predTaken != 0,
                target, predTarget);
            @(negedge clk);
            inValid = 1'b0;
        end
    endtask

    // Let the group retire and wait for ten quiet cycles
    task automatic runGroup();
        int quiet;
        quiet = 0;
        stallReq = 1'b0;
        while (quiet < 10) begin
            @(negedge clk);
            quiet = (commitValid || redirectValid || !inReady) ? 0 : quiet + 1;
            if (gapPcs.size() != 0 && commitValid && commitPc == gapPcs[0]) begin
                stallReq = 1'b1;
                repeat ($urandom_range(6, 2)) @(negedge clk);
                stallReq = 1'b0;
                void'(gapPcs.pop_front());
            end
        end
        stallReq = 1'b1;
    endtask

    task automatic lookupEntry(input string line);
        logic [commitPkg::PC_WIDTH-1:0] pc;
        logic [commitPkg::PC_WIDTH-1:0] target;
        int hit;
        int taken;
        if ($sscanf(line, "L %h %d %d %h", pc, hit, taken, target) != 4) begin
            reportBadLine(line);
        end else begin
            lookupPc = pc;
            @(negedge clk);
            checkerInst.checkLookup(pc, hit != 0, taken != 0, target);
        end
    endtask

    initial begin
        int fd;
        string line;
        int testId;
        bit inTest;
        void'($urandom(32'hceb4c428));
        inValid = 1'b0;
        inPc = '0;
        inKind = commitPkg::uopPlain;
        inBranchKind = commitPkg::typeNormal;
        inTaken = 1'b0;
        inPredTaken = 1'b0;
        inTarget = '0;
        inPredTarget = '0;
        stallReq = 1'b1;
        lookupPc = '0;
        fd = $fopen("tests/commitTests.dat", "r");
        if (fd == 0) begin
            $display("Could not open tests/commitTests.dat");
            badLines++;
        end else begin
            while (!$feof(fd)) begin
                if ($fgets(line, fd) != 0 && line.len() > 1 && line.getc(0) != "#") begin
                    lines.push_back(line);
                    if (line.getc(0) == "T") begin
                        numTests++;
                    end
                end
            end
            $fclose(fd);
        end
        while (rstN !== 1'b1) @(negedge clk);
        @(negedge clk);
        foreach (lines[i]) begin
            case (lines[i].getc(0))
                "T": begin
                    if (inTest) begin
                        checkerInst.finishTest();
                    end
                    void'($sscanf(lines[i], "T %d", testId));
                    repeat ($urandom_range(5, 1)) @(negedge clk);
                    checkerInst.startTest(testId);
                    inTest = 1'b1;
                end
                "E": pushEntry(lines[i]);
                "R": runGroup();
                "L": lookupEntry(lines[i]);
                default: reportBadLine(lines[i]);
            endcase
        end
        if (inTest) begin
            checkerInst.finishTest();
        end
        checkerInst.printCounts();
        if (badLines == 0 && numTests > 0 && checkerInst.testsRun == numTests
                && checkerInst.testsFailed == 0 && checkerInst.testErrors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

    // 200 cycles for each test plus reset
    initial begin
        wait (numTests > 0);
        repeat (numTests * 200 + 20) @(posedge clk);
        $display("Run stopped by the watchdog before all tests finished");
        $display("SOME TESTS FAILED");
        $finish;
    end

endmodule

// File: tests/commitTests.dat
# T id | E pc kind bkind taken predTaken target predTarget gap | R runs group | L pc hit taken target
# kind 0 plain 1 branch 2 slot, bkind 0 normal 1 cond 2 jump 3 call 4 ret, gap 1 delays the entry
T 1
E 00001000 0 0 0 0 00000000 00000000 0
E 00001004 1 1 1 1 00002000 00002000 0
E 00001008 2 0 0 0 00000000 00000000 0
E 0000100c 0 0 0 0 00000000 00000000 0
E 00001010 1 2 1 1 00003000 00003000 0
E 00001014 2 0 0 0 00000000 00000000 0
R
L 00001004 1 1 00002000
L 00001010 1 1 00003000
T 2
E 00001100 0 0 0 0 00000000 00000000 0
E 00001104 1 1 1 0 00001200 00001200 0
E 00001108 2 0 0 0 00000000 00000000 0
E 0000110c 0 0 0 0 00000000 00000000 0
E 00001110 0 0 0 0 00000000 00000000 0
R
L 00001104 1 1 00001200
T 3
E 00001208 1 1 0 1 00001300 00001300 0
E 0000120c 2 0 0 0 00000000 00000000 0
E 00001210 0 0 0 0 00000000 00000000 0
R
L 00001208 1 0 00001300
T 4
E 00001300 1 1 0 0 00001500 00001600 0
E 00001304 2 0 0 0 00000000 00000000 0
E 00001318 1 3 1 1 00001400 00001480 0
E 0000131c 2 0 0 0 00000000 00000000 0
E 00001320 0 0 0 0 00000000 00000000 0
R
L 00001300 1 0 00001500
L 00001318 1 1 00001400
T 5
E 00001424 1 4 1 1 00001800 00001700 0
E 00001428 2 0 0 0 00000000 00000000 1
E 0000142c 0 0 0 0 00000000 00000000 0
R
L 00001424 1 1 00001800
T 6
E 00001530 1 1 0 1 00001900 00001900 0
E 00001534 2 0 0 0 00000000 00000000 1
E 00001538 0 0 0 0 00000000 00000000 0
R
L 00001530 1 0 00001900
L 00002530 0 0 00000000
L 0000203c 0 0 00000000

// File: commitSubsystem.f
common/commitPkg.sv
common/robCommitIf.sv
common/backendIf.sv
rob/robQueue.sv
commit/commitUnit.sv
logic/branchTargetBuffer.sv
logic/commitSubsystem.sv
tests/clockGen.sv
tests/commitChecker.sv
tests/commitTb.sv
